//--- compile.f
+incdir+dv
hw/scroll_mmr_pkg.sv
hw/mmr_decode.sv
hw/scroll_bank_regs.sv
hw/scroll_select.sv
hw/scroll_status.sv
hw/scroll_mmr.sv
dv/tb_scroll_mmr.sv

//--- dv/scroll_model.svh
// Model of the scroll register map, bank selection and status bytes, included by the testbench
`ifndef SCROLL_MODEL_SVH
`define SCROLL_MODEL_SVH

localparam int KIND_PAGES = 0;
localparam int KIND_VPOS  = 1;
localparam int KIND_HPOS  = 2;

logic [15:0] model_regs [0:11];
bit          model_alt1;
bit          model_alt2;

// Byte offset of register idx inside the window
function automatic logic [8:0] reg_offset(input int idx);
    return (idx < 4) ? 9'(9'h080 + 2 * idx) : 9'(9'h090 + 2 * (idx - 4));
endfunction

// Register index for a byte offset, -1 when nothing is mapped there
function automatic int offset_to_idx(input logic [8:0] off);
    if (off >= 9'h080 && off <= 9'h086) return (off - 9'h080) / 2;
    if (off >= 9'h090 && off <= 9'h09e) return 4 + (off - 9'h090) / 2;
    return -1;
endfunction

function automatic void model_reset();
    for (int i = 0; i < 12; i++) model_regs[i] = 16'h0000;
    model_alt1 = 1'b0;
    model_alt2 = 1'b0;
endfunction

// One bus cycle as the CPU sees it
function automatic void model_bus_write(input bit cs, input logic [11:1] addr,
                                        input logic [15:0] data, input logic [1:0] strobes);
    int idx;
    idx = offset_to_idx({addr[8:1], 1'b0});
    if (!cs || addr[11:9] != 3'd7 || strobes == 2'b11 || idx < 0) return;
    if (!strobes[0]) model_regs[idx][7:0] = data[7:0];   // Strobes are active low
    if (!strobes[1]) model_regs[idx][15:8] = data[15:8];
endfunction

// Pages, vpos and hpos blocks of four, alternate bank two words up
function automatic logic [15:0] expected_word(input int layer, input int kind);
    bit alt;
    alt = (layer == 1) ? model_alt1 : model_alt2;
    return model_regs[kind * 4 + (alt ? 2 : 0) + (layer - 1)];
endfunction

function automatic logic [7:0] expected_status(input logic [7:0] a);
    logic [15:0] w;
    logic [15:0] vpos1;
    logic [15:0] hpos1;
    logic [15:0] vpos2;
    logic [15:0] hpos2;
    vpos1 = expected_word(1, KIND_VPOS);
    hpos1 = expected_word(1, KIND_HPOS);
    vpos2 = expected_word(2, KIND_VPOS);
    hpos2 = expected_word(2, KIND_HPOS);
    case (a[3:1])
        3'd0: w = expected_word(1, KIND_PAGES);
        3'd1: w = expected_word(2, KIND_PAGES);
        3'd2: w = vpos1;
        3'd3: w = vpos2;
        3'd4: w = hpos1;
        default: w = hpos2;
    endcase
    if (a < 8'd12) return a[0] ? w[15:8] : w[7:0];
    if (a == 8'd12) begin
        return {2'b00, vpos2[15], hpos2[15], 2'b00, vpos1[15], hpos1[15]};
    end
    return 8'h00;
endfunction

`endif

//--- dv/tb_scroll_mmr.sv
// Testbench for the scroll register block, random writes, bank switching and status reads
`timescale 1ns/100ps

module tb_scroll_mmr;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_FULL     = 200;
    localparam int NUM_BYTE     = 150;
    localparam int NUM_IGNORE   = 100;
    localparam int NUM_ALT      = 100;
    localparam int NUM_STATUS   = 150;
    localparam int NUM_TXN      = NUM_FULL + NUM_BYTE + NUM_IGNORE + NUM_ALT + NUM_STATUS;
    localparam int CYCLE_LIMIT  = NUM_TXN * 5 + 2500;  // Up to 5 cycles each, plus margin

    logic        clk;
    logic        rst_n;
    logic        char_cs;
    logic [11:1] cpu_addr;
    logic [15:0] cpu_dout;
    logic [1:0]  dsn;
    logic        altscr1_en;
    logic        altscr2_en;
    logic [7:0]  st_addr;
    logic [15:0] scr1_pages, scr2_pages, scr1_hpos, scr1_vpos, scr2_hpos, scr2_vpos;
    logic        rowscr1_en, rowscr2_en, colscr1_en, colscr2_en;
    logic [7:0]  st_dout;
    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;

    `include "scroll_model.svh"

    scroll_mmr dut (
        .clk(clk), .rst_n(rst_n), .char_cs(char_cs), .cpu_addr(cpu_addr),
        .cpu_dout(cpu_dout), .dsn(dsn), .altscr1_en(altscr1_en), .altscr2_en(altscr2_en),
        .scr1_pages(scr1_pages), .scr2_pages(scr2_pages), .scr1_hpos(scr1_hpos),
        .scr1_vpos(scr1_vpos), .scr2_hpos(scr2_hpos), .scr2_vpos(scr2_vpos),
        .rowscr1_en(rowscr1_en), .rowscr2_en(rowscr2_en), .colscr1_en(colscr1_en),
        .colscr2_en(colscr2_en), .st_addr(st_addr), .st_dout(st_dout)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Checks: %0d, errors: %0d", check_count, error_count);
            $display("tests failed");
            $finish;
        end
    end

    task automatic compare_word(input string name, input logic [15:0] got,
                                input logic [15:0] exp);
        check_count++;
        assert (got === exp) else begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_outputs();
        logic [15:0] hpos1_exp;
        logic [15:0] hpos2_exp;
        logic [15:0] vpos1_exp;
        logic [15:0] vpos2_exp;
        hpos1_exp = expected_word(1, KIND_HPOS);
        hpos2_exp = expected_word(2, KIND_HPOS);
        vpos1_exp = expected_word(1, KIND_VPOS);
        vpos2_exp = expected_word(2, KIND_VPOS);
        compare_word("scr1_pages", scr1_pages, expected_word(1, KIND_PAGES));
        compare_word("scr2_pages", scr2_pages, expected_word(2, KIND_PAGES));
        compare_word("scr1_hpos", scr1_hpos, hpos1_exp);
        compare_word("scr1_vpos", scr1_vpos, vpos1_exp);
        compare_word("scr2_hpos", scr2_hpos, hpos2_exp);
        compare_word("scr2_vpos", scr2_vpos, vpos2_exp);
        // Enables come from bit 15 of the selected positions
        compare_word("rowscr1_en", {15'd0, rowscr1_en}, {15'd0, hpos1_exp[15]});
        compare_word("rowscr2_en", {15'd0, rowscr2_en}, {15'd0, hpos2_exp[15]});
        compare_word("colscr1_en", {15'd0, colscr1_en}, {15'd0, vpos1_exp[15]});
        compare_word("colscr2_en", {15'd0, colscr2_en}, {15'd0, vpos2_exp[15]});
    endtask

    function automatic logic [11:1] make_addr(input logic [2:0] win, input logic [8:0] off);
        return {win, off[8:1]};
    endfunction

    task automatic bus_write(input bit cs, input logic [11:1] addr, input logic [15:0] data,
                             input logic [1:0] strobes, input bit a1, input bit a2);
        @(negedge clk);
        char_cs    = cs;
        cpu_addr   = addr;
        cpu_dout   = data;
        dsn        = strobes;
        altscr1_en = a1;
        altscr2_en = a2;
        model_bus_write(cs, addr, data, strobes);
        model_alt1 = a1;
        model_alt2 = a2;
        @(negedge clk);
        char_cs = 1'b0;
        dsn     = 2'b11;
        repeat (2) @(negedge clk);  // Two cycle write to output latency
        check_outputs();
    endtask

    task automatic set_alt(input bit a1, input bit a2);
        @(negedge clk);
        altscr1_en = a1;
        altscr2_en = a2;
        model_alt1 = a1;
        model_alt2 = a2;
        @(negedge clk);
        check_outputs();
    endtask

    task automatic read_status(input logic [7:0] a);
        @(negedge clk);
        st_addr = a;
        @(negedge clk);
        compare_word("st_dout", {8'h00, st_dout}, {8'h00, expected_status(a)});
    endtask

    initial begin
        int          idx;
        logic [1:0]  strobes;
        logic [11:1] addr;
        void'($urandom(61));
        rst_n      = 1'b0;
        char_cs    = 1'b0;
        cpu_addr   = '0;
        cpu_dout   = '0;
        dsn        = 2'b11;
        altscr1_en = 1'b0;
        altscr2_en = 1'b0;
        st_addr    = '0;
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_outputs();
        compare_word("st_dout", {8'h00, st_dout}, 16'h0000);

        // Full words, every register first, then random ones
        for (int n = 0; n < NUM_FULL; n++) begin
            idx = (n < 12) ? n : $urandom_range(11, 0);
            bus_write(1'b1, make_addr(3'd7, reg_offset(idx)), 16'($urandom), 2'b00,
                      $urandom_range(1, 0), $urandom_range(1, 0));
        end

        // Single byte lanes
        for (int n = 0; n < NUM_BYTE; n++) begin
            idx     = $urandom_range(11, 0);
            strobes = $urandom_range(1, 0) ? 2'b01 : 2'b10;
            bus_write(1'b1, make_addr(3'd7, reg_offset(idx)), 16'($urandom), strobes,
                      model_alt1, model_alt2);
        end

        // Writes that must be dropped
        for (int n = 0; n < NUM_IGNORE; n++) begin
            idx     = $urandom_range(11, 0);
            strobes = 2'($urandom_range(2, 0));
            case (n % 4)
                0: addr = make_addr(3'd7, reg_offset(idx));                     // char_cs low
                1: addr = make_addr(3'($urandom_range(6, 0)), reg_offset(idx)); // Other window
                2: addr = make_addr(3'd7, reg_offset(idx));                     // No strobes
                default: addr = make_addr(3'd7, 9'(9'h088 + 2 * $urandom_range(3, 0)));
            endcase
            if (n % 4 == 2) strobes = 2'b11;
            bus_write(n % 4 != 0, addr, 16'($urandom), strobes, model_alt1, model_alt2);
        end

        for (int n = 0; n < NUM_ALT; n++) begin
            set_alt($urandom_range(1, 0), $urandom_range(1, 0));
        end

        // Sweep the low addresses, then random ones, with the banks switching now and then
        for (int n = 0; n < NUM_STATUS; n++) begin
            if (n % 8 == 7) set_alt($urandom_range(1, 0), $urandom_range(1, 0));
            read_status((n < 16) ? 8'(n) : 8'($urandom_range(255, 0)));
        end

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- hw/mmr_decode.sv
// CPU write decoder, turns a strobed bus write into a one-cycle register write command
`timescale 1ns/100ps

module mmr_decode (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      char_cs,
    input  scroll_mmr_pkg::cpu_addr_t cpu_addr,
    input  scroll_mmr_pkg::word_t     cpu_dout,
    input  logic [1:0]                dsn,
    output logic                      wr_en,
    output scroll_mmr_pkg::reg_idx_t  wr_idx,
    output scroll_mmr_pkg::byte_en_t  wr_be,
    output scroll_mmr_pkg::word_t     wr_data
);
    import scroll_mmr_pkg::*;

    logic [8:0] byte_off;  // Byte offset from the first register
    logic       bus_wr;
    logic       mapped;
    reg_idx_t   idx;

    assign byte_off = {cpu_addr[8:1], 1'b0} - REG_BASE;

    // Chip select, window and at least one byte strobe
    assign bus_wr = char_cs && (cpu_addr[11:9] == MMR_WINDOW) && (dsn != 2'b11);

    // Pages at 0x00-0x06, positions at 0x10-0x1e, gap in between
    assign mapped = (byte_off < 9'h020) && (byte_off[4:3] != 2'b01);

    // Close the gap so the positions follow the pages
    assign idx = byte_off[4] ? (byte_off[4:1] - 4'd4) : byte_off[4:1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= bus_wr && mapped;
        end
    end

    // Command fields, only meaningful with wr_en
    always_ff @(posedge clk) begin
        wr_idx  <= idx;
        wr_be   <= ~dsn;
        wr_data <= cpu_dout;
    end

    // Unmapped offsets must never leak through as a write
    wr_idx_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_en |-> (wr_idx < NUM_REGS)
    );

endmodule

//--- hw/scroll_bank_regs.sv
// Storage for the standard and alternate scroll banks, with byte-lane write merging
`timescale 1ns/100ps

module scroll_bank_regs (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     wr_en,
    input  scroll_mmr_pkg::reg_idx_t wr_idx,
    input  scroll_mmr_pkg::byte_en_t wr_be,
    input  scroll_mmr_pkg::word_t    wr_data,
    output scroll_mmr_pkg::bank_t    bank
);
    import scroll_mmr_pkg::*;

    bank_t regs;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '0;
        end else begin
            for (int i = 0; i < NUM_REGS; i++) begin
                if (wr_en && (wr_idx == reg_idx_t'(i))) begin
                    // Each lane keeps the stored byte unless strobed
                    if (wr_be[0]) begin
                        regs[i][7:0] <= wr_data[7:0];
                    end
                    if (wr_be[1]) begin
                        regs[i][15:8] <= wr_data[15:8];
                    end
                end
            end
        end
    end

    assign bank = regs;

    // Decoder filters out cycles with both strobes high
    wr_has_lane: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_en |-> (wr_be != '0)
    );

endmodule

//--- hw/scroll_mmr.sv
// Scroll register block top level, CPU writes in, selected scroll values and status out
`timescale 1ns/100ps

module scroll_mmr (
    input  logic                      clk,
    input  logic                      rst_n,
    // CPU bus
    input  logic                      char_cs,
    input  scroll_mmr_pkg::cpu_addr_t cpu_addr,
    input  scroll_mmr_pkg::word_t     cpu_dout,
    input  logic [1:0]                dsn,
    // Video timing side
    input  logic                      altscr1_en,
    input  logic                      altscr2_en,
    // Selected scroll values
    output scroll_mmr_pkg::word_t     scr1_pages,
    output scroll_mmr_pkg::word_t     scr2_pages,
    output scroll_mmr_pkg::word_t     scr1_hpos,
    output scroll_mmr_pkg::word_t     scr1_vpos,
    output scroll_mmr_pkg::word_t     scr2_hpos,
    output scroll_mmr_pkg::word_t     scr2_vpos,
    output logic                      rowscr1_en,
    output logic                      rowscr2_en,
    output logic                      colscr1_en,
    output logic                      colscr2_en,
    // Debug readback
    input  scroll_mmr_pkg::st_addr_t  st_addr,
    output scroll_mmr_pkg::st_byte_t  st_dout
);
    import scroll_mmr_pkg::*;

    logic     wr_en;
    reg_idx_t wr_idx;
    byte_en_t wr_be;
    word_t    wr_data;
    bank_t    bank;

    mmr_decode u_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .char_cs  (char_cs),
        .cpu_addr (cpu_addr),
        .cpu_dout (cpu_dout),
        .dsn      (dsn),
        .wr_en    (wr_en),
        .wr_idx   (wr_idx),
        .wr_be    (wr_be),
        .wr_data  (wr_data)
    );

    scroll_bank_regs u_bank (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (wr_en),
        .wr_idx  (wr_idx),
        .wr_be   (wr_be),
        .wr_data (wr_data),
        .bank    (bank)
    );

    scroll_select u_select (
        .clk        (clk),
        .rst_n      (rst_n),
        .bank       (bank),
        .altscr1_en (altscr1_en),
        .altscr2_en (altscr2_en),
        .scr1_pages (scr1_pages),
        .scr2_pages (scr2_pages),
        .scr1_hpos  (scr1_hpos),
        .scr1_vpos  (scr1_vpos),
        .scr2_hpos  (scr2_hpos),
        .scr2_vpos  (scr2_vpos),
        .rowscr1_en (rowscr1_en),
        .rowscr2_en (rowscr2_en),
        .colscr1_en (colscr1_en),
        .colscr2_en (colscr2_en)
    );

    // Reads the registered outputs, not the banks
    scroll_status u_status (
        .clk        (clk),
        .rst_n      (rst_n),
        .st_addr    (st_addr),
        .scr1_pages (scr1_pages),
        .scr2_pages (scr2_pages),
        .scr1_hpos  (scr1_hpos),
        .scr1_vpos  (scr1_vpos),
        .scr2_hpos  (scr2_hpos),
        .scr2_vpos  (scr2_vpos),
        .rowscr1_en (rowscr1_en),
        .rowscr2_en (rowscr2_en),
        .colscr1_en (colscr1_en),
        .colscr2_en (colscr2_en),
        .st_dout    (st_dout)
    );

endmodule

//--- hw/scroll_mmr_pkg.sv
// Shared widths, register map and status map for the scroll register block
package scroll_mmr_pkg;

    // Register file size, needed before the bank type
    localparam int NUM_REGS = 12;

    typedef logic [15:0] word_t;      // CPU data word or scroll register
    typedef logic [11:1] cpu_addr_t;  // CPU word address
    typedef logic [1:0]  byte_en_t;   // Bit 1 is the high byte
    typedef logic [3:0]  reg_idx_t;
    // Word i sits in slice i
    typedef word_t [NUM_REGS-1:0] bank_t;
    typedef logic [7:0]  st_addr_t;
    typedef logic [7:0]  st_byte_t;

    // Address bits 11 to 9 that select the register window
    localparam logic [2:0] MMR_WINDOW = 3'd7;
    localparam logic [8:0] REG_BASE   = 9'h080;  // First register inside the window

    // Pages at 0x080-0x086
    localparam reg_idx_t IDX_PAGES1_STD = 4'd0;
    localparam reg_idx_t IDX_PAGES2_STD = 4'd1;
    localparam reg_idx_t IDX_PAGES1_ALT = 4'd2;
    localparam reg_idx_t IDX_PAGES2_ALT = 4'd3;
    // Vertical positions at 0x090-0x096
    localparam reg_idx_t IDX_VPOS1_STD  = 4'd4;
    localparam reg_idx_t IDX_VPOS2_STD  = 4'd5;
    localparam reg_idx_t IDX_VPOS1_ALT  = 4'd6;
    localparam reg_idx_t IDX_VPOS2_ALT  = 4'd7;
    // Horizontal positions at 0x098-0x09e
    localparam reg_idx_t IDX_HPOS1_STD  = 4'd8;
    localparam reg_idx_t IDX_HPOS2_STD  = 4'd9;
    localparam reg_idx_t IDX_HPOS1_ALT  = 4'd10;
    localparam reg_idx_t IDX_HPOS2_ALT  = 4'd11;

    // Status readback, low byte first, high byte at the next address
    localparam st_addr_t ST_PAGES1 = 8'd0;
    localparam st_addr_t ST_PAGES2 = 8'd2;
    localparam st_addr_t ST_VPOS1  = 8'd4;
    localparam st_addr_t ST_VPOS2  = 8'd6;
    localparam st_addr_t ST_HPOS1  = 8'd8;
    localparam st_addr_t ST_HPOS2  = 8'd10;
    localparam st_addr_t ST_FLAGS  = 8'd12;  // Row and column scroll enables

endpackage

//--- hw/scroll_select.sv
// Per-layer bank selection into registered scroll outputs plus row and column scroll enables
`timescale 1ns/100ps

module scroll_select (
    input  logic                  clk,
    input  logic                  rst_n,
    input  scroll_mmr_pkg::bank_t bank,
    input  logic                  altscr1_en,
    input  logic                  altscr2_en,
    output scroll_mmr_pkg::word_t scr1_pages,
    output scroll_mmr_pkg::word_t scr2_pages,
    output scroll_mmr_pkg::word_t scr1_hpos,
    output scroll_mmr_pkg::word_t scr1_vpos,
    output scroll_mmr_pkg::word_t scr2_hpos,
    output scroll_mmr_pkg::word_t scr2_vpos,
    output logic                  rowscr1_en,
    output logic                  rowscr2_en,
    output logic                  colscr1_en,
    output logic                  colscr2_en
);
    import scroll_mmr_pkg::*;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scr1_pages <= '0;
            scr2_pages <= '0;
            scr1_hpos  <= '0;
            scr1_vpos  <= '0;
            scr2_hpos  <= '0;
            scr2_vpos  <= '0;
        end else begin
            // Layer 1
            scr1_pages <= altscr1_en ? bank[IDX_PAGES1_ALT] : bank[IDX_PAGES1_STD];
            scr1_hpos  <= altscr1_en ? bank[IDX_HPOS1_ALT]  : bank[IDX_HPOS1_STD];
            scr1_vpos  <= altscr1_en ? bank[IDX_VPOS1_ALT]  : bank[IDX_VPOS1_STD];
            // Layer 2
            scr2_pages <= altscr2_en ? bank[IDX_PAGES2_ALT] : bank[IDX_PAGES2_STD];
            scr2_hpos  <= altscr2_en ? bank[IDX_HPOS2_ALT]  : bank[IDX_HPOS2_STD];
            scr2_vpos  <= altscr2_en ? bank[IDX_VPOS2_ALT]  : bank[IDX_VPOS2_STD];
        end
    end

    // Top bit of each position doubles as a mode flag
    assign rowscr1_en = scr1_hpos[15];
    assign rowscr2_en = scr2_hpos[15];
    assign colscr1_en = scr1_vpos[15];
    assign colscr2_en = scr2_vpos[15];

    // Row enable of layer 1 tracks bit 15 of the hpos selected one cycle earlier
    row1_follows_hpos: assert property (
        @(posedge clk) disable iff (!rst_n)
        rowscr1_en == $past(altscr1_en ? bank[IDX_HPOS1_ALT][15] : bank[IDX_HPOS1_STD][15])
    );

endmodule

//--- hw/scroll_status.sv
// Debug readback of the selected scroll state, one byte per status address
`timescale 1ns/100ps

module scroll_status (
    input  logic                     clk,
    input  logic                     rst_n,
    input  scroll_mmr_pkg::st_addr_t st_addr,
    input  scroll_mmr_pkg::word_t    scr1_pages,
    input  scroll_mmr_pkg::word_t    scr2_pages,
    input  scroll_mmr_pkg::word_t    scr1_hpos,
    input  scroll_mmr_pkg::word_t    scr1_vpos,
    input  scroll_mmr_pkg::word_t    scr2_hpos,
    input  scroll_mmr_pkg::word_t    scr2_vpos,
    input  logic                     rowscr1_en,
    input  logic                     rowscr2_en,
    input  logic                     colscr1_en,
    input  logic                     colscr2_en,
    output scroll_mmr_pkg::st_byte_t st_dout
);
    import scroll_mmr_pkg::*;

    st_byte_t flags;

    assign flags = {2'b00, colscr2_en, rowscr2_en, 2'b00, colscr1_en, rowscr1_en};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            st_dout <= '0;
        end else begin
            case (st_addr)
                ST_PAGES1:     st_dout <= scr1_pages[7:0];
                ST_PAGES1 + 1: st_dout <= scr1_pages[15:8];
                ST_PAGES2:     st_dout <= scr2_pages[7:0];
                ST_PAGES2 + 1: st_dout <= scr2_pages[15:8];
                ST_VPOS1:      st_dout <= scr1_vpos[7:0];
                ST_VPOS1 + 1:  st_dout <= scr1_vpos[15:8];
                ST_VPOS2:      st_dout <= scr2_vpos[7:0];
                ST_VPOS2 + 1:  st_dout <= scr2_vpos[15:8];
                ST_HPOS1:      st_dout <= scr1_hpos[7:0];
                ST_HPOS1 + 1:  st_dout <= scr1_hpos[15:8];
                ST_HPOS2:      st_dout <= scr2_hpos[7:0];
                ST_HPOS2 + 1:  st_dout <= scr2_hpos[15:8];
                ST_FLAGS:      st_dout <= flags;
                default:       st_dout <= '0;  // Unused addresses read zero
            endcase
        end
    end

endmodule
